/* rtl/wisc_macros.svh */
`ifndef WISC_MACROS_SVH
`define WISC_MACROS_SVH

// Data and PC width
`define WISC_WIDTH 16

// Opcode field
`define WISC_OPC_HI 15
`define WISC_OPC_LO 11

// Sequential PC increment
`define WISC_PC_STEP 2

`endif

/* rtl/wisc_pkg.sv */
`include "wisc_macros.svh"

package wisc_pkg;

  typedef logic [`WISC_WIDTH-1:0] word_t;

  // Kept WISC opcodes only
  typedef enum logic [4:0] {
    OPC_HALT  = 5'b00000,
    OPC_NOP   = 5'b00001,
    OPC_J     = 5'b00100,
    OPC_JR    = 5'b00101,
    OPC_ADDI  = 5'b01000,
    OPC_SUBI  = 5'b01001,
    OPC_XORI  = 5'b01010,
    OPC_ANDNI = 5'b01011,
    OPC_BEQZ  = 5'b01100,
    OPC_BNEZ  = 5'b01101,
    OPC_BLTZ  = 5'b01110,
    OPC_BGEZ  = 5'b01111,
    OPC_SLBI  = 5'b10010,
    OPC_ROLI  = 5'b10100,
    OPC_SLLI  = 5'b10101,
    OPC_RORI  = 5'b10110,
    OPC_SRLI  = 5'b10111,
    OPC_BTR   = 5'b11001,
    OPC_SHIFT = 5'b11010,
    OPC_ARITH = 5'b11011,
    OPC_SEQ   = 5'b11100,
    OPC_SLT   = 5'b11101,
    OPC_SLE   = 5'b11110,
    OPC_SCO   = 5'b11111
  } opcode_e;

  // Low two bits line up with the shift function field
  typedef enum logic [2:0] {
    ALU_ROL  = 3'b000,
    ALU_SLL  = 3'b001,
    ALU_ROR  = 3'b010,
    ALU_SRL  = 3'b011,
    ALU_ADD  = 3'b100,
    ALU_XOR  = 3'b110,
    ALU_ANDN = 3'b111
  } alu_op_e;

  // Set meaning first, branch meaning second
  typedef enum logic [1:0] {
    COND_EQ_EQZ = 2'b00,
    COND_LT_NEZ = 2'b01,
    COND_LE_LTZ = 2'b10,
    COND_CO_GEZ = 2'b11
  } cond_e;

  typedef enum logic [1:0] {
    RES_ALU  = 2'b00,
    RES_SLBI = 2'b01,
    RES_BTR  = 2'b10,
    RES_COND = 2'b11
  } res_sel_e;

  typedef enum logic [1:0] {
    B_RT   = 2'b00,
    B_IMM5 = 2'b01,
    B_ZERO = 2'b10
  } b_sel_e;

endpackage

/* rtl/ex_ctrl_if.sv */
`timescale 1ns/1ps

interface ex_ctrl_if
  import wisc_pkg::*;
();

  alu_op_e  alu_op;
  b_sel_e   b_sel;
  logic     cin;
  logic     inv_a;
  logic     inv_b;
  logic     sign;
  cond_e    cond;
  logic     jump;
  logic     jump_reg;
  logic     branch;
  logic     halt;
  res_sel_e res_sel;
  word_t    imm5;
  word_t    imm8;
  word_t    imm11;

  modport dec (
    output alu_op, b_sel, cin, inv_a, inv_b, sign, cond,
    output jump, jump_reg, branch, halt, res_sel, imm5, imm8, imm11
  );

  modport exe (
    input alu_op, b_sel, cin, inv_a, inv_b, sign, cond,
    input jump, jump_reg, branch, halt, res_sel, imm5, imm8, imm11
  );

endinterface

/* rtl/ex_decode.sv */
`timescale 1ns/1ps
`include "wisc_macros.svh"

module ex_decode
  import wisc_pkg::*;
(
  input word_t      instr,
  ex_ctrl_if.dec    ctrl
);

  opcode_e    opc;
  logic [1:0] fn;
  logic       zext5;
  logic       zext8;
  logic       opc_valid;

  assign opc = opcode_e'(instr[`WISC_OPC_HI:`WISC_OPC_LO]);
  assign fn  = instr[1:0];

  always_comb begin
    ctrl.alu_op   = ALU_ADD;
    ctrl.b_sel    = B_RT;
    ctrl.cin      = 1'b0;
    ctrl.inv_a    = 1'b0;
    ctrl.inv_b    = 1'b0;
    ctrl.sign     = 1'b0;
    ctrl.cond     = cond_e'(instr[12:11]);
    ctrl.jump     = 1'b0;
    ctrl.jump_reg = 1'b0;
    ctrl.branch   = 1'b0;
    ctrl.halt     = 1'b0;
    ctrl.res_sel  = RES_ALU;
    zext5         = 1'b0;
    zext8         = 1'b0;
    opc_valid     = 1'b1;
    case (opc)
      OPC_HALT:  ctrl.halt = 1'b1;
      OPC_NOP:   ;
      OPC_ADDI:  begin
        ctrl.b_sel = B_IMM5;
        ctrl.sign  = 1'b1;
      end
      // Immediate minus Rs
      OPC_SUBI:  begin
        ctrl.b_sel = B_IMM5;
        ctrl.inv_a = 1'b1;
        ctrl.cin   = 1'b1;
        ctrl.sign  = 1'b1;
      end
      OPC_XORI:  begin
        ctrl.b_sel  = B_IMM5;
        ctrl.alu_op = ALU_XOR;
        zext5       = 1'b1;
      end
      OPC_ANDNI: begin
        ctrl.b_sel  = B_IMM5;
        ctrl.alu_op = ALU_ANDN;
        zext5       = 1'b1;
      end
      OPC_ROLI, OPC_SLLI, OPC_RORI, OPC_SRLI: begin
        ctrl.b_sel  = B_IMM5;
        ctrl.alu_op = alu_op_e'({1'b0, instr[12:11]});
      end
      OPC_SHIFT: ctrl.alu_op = alu_op_e'({1'b0, fn});
      OPC_ARITH: begin
        case (fn)
          2'b00: ctrl.sign = 1'b1;
          2'b01: begin
            ctrl.inv_a = 1'b1;
            ctrl.cin   = 1'b1;
            ctrl.sign  = 1'b1;
          end
          2'b10: ctrl.alu_op = ALU_XOR;
          default: ctrl.alu_op = ALU_ANDN;
        endcase
      end
      OPC_SLBI:  begin
        ctrl.res_sel = RES_SLBI;
        zext8        = 1'b1;
      end
      OPC_BTR:   ctrl.res_sel = RES_BTR;
      // Compare as Rt minus Rs
      OPC_SEQ, OPC_SLT, OPC_SLE: begin
        ctrl.inv_a   = 1'b1;
        ctrl.cin     = 1'b1;
        ctrl.sign    = 1'b1;
        ctrl.res_sel = RES_COND;
      end
      OPC_SCO:   ctrl.res_sel = RES_COND;
      OPC_BEQZ, OPC_BNEZ, OPC_BLTZ, OPC_BGEZ: begin
        ctrl.b_sel  = B_ZERO;
        ctrl.branch = 1'b1;
        ctrl.sign   = 1'b1;
      end
      OPC_J:     ctrl.jump = 1'b1;
      OPC_JR:    begin
        ctrl.jump     = 1'b1;
        ctrl.jump_reg = 1'b1;
      end
      default:   opc_valid = 1'b0;
    endcase
  end

  assign ctrl.imm5  = zext5 ? word_t'(instr[4:0]) : word_t'($signed(instr[4:0]));
  assign ctrl.imm8  = zext8 ? word_t'(instr[7:0]) : word_t'($signed(instr[7:0]));
  assign ctrl.imm11 = word_t'($signed(instr[10:0]));

  always_comb begin
    if (opc_valid && !$isunknown(instr)) begin
      assert final (!$isunknown(ctrl.res_sel))
        else $error("ex_decode: unknown res_sel for opcode %b", opc);
    end
  end

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps
`include "wisc_macros.svh"

module alu
  import wisc_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  input  logic    cin,
  input  logic    inv_a,
  input  logic    inv_b,
  input  logic    sign,
  output word_t   out,
  output logic    cout,
  output logic    ofl,
  output logic    zero
);

  word_t                 a_in;
  word_t                 b_in;
  word_t                 sum;
  logic [3:0]            cnt;
  logic [4:0]            rcnt;
  logic [`WISC_WIDTH:0]  wide_sum;

  assign a_in = inv_a ? ~a : a;
  assign b_in = inv_b ? ~b : b;

  // Shift amount from the low nibble of B
  assign cnt  = b_in[3:0];
  assign rcnt = 5'd16 - {1'b0, cnt};

  assign {cout, sum} = {1'b0, a_in} + {1'b0, b_in} + {{`WISC_WIDTH{1'b0}}, cin};

  always_comb begin
    case (op)
      ALU_ROL:  out = (a_in << cnt) | (a_in >> rcnt);
      ALU_SLL:  out = a_in << cnt;
      ALU_ROR:  out = (a_in >> cnt) | (a_in << rcnt);
      ALU_SRL:  out = a_in >> cnt;
      ALU_ADD:  out = sum;
      ALU_XOR:  out = a_in ^ b_in;
      ALU_ANDN: out = a_in & ~b_in;
      default:  out = sum;
    endcase
  end

  // Signed overflow when like-signed operands give an unlike-signed sum
  assign ofl = sign ? ((a_in[`WISC_WIDTH-1] == b_in[`WISC_WIDTH-1]) &&
                       (sum[`WISC_WIDTH-1] != a_in[`WISC_WIDTH-1]))
                    : cout;

  assign zero = (out == '0);

  // Sign-extended reference sum for the overflow check
  assign wide_sum = {a_in[`WISC_WIDTH-1], a_in} + {b_in[`WISC_WIDTH-1], b_in} +
                    {{`WISC_WIDTH{1'b0}}, cin};

  always_comb begin
    if (op == ALU_ADD && sign && !$isunknown({a_in, b_in, cin})) begin
      assert final (ofl == (wide_sum[`WISC_WIDTH] != wide_sum[`WISC_WIDTH-1]))
        else $error("alu: signed overflow flag disagrees with operand signs");
    end
  end

endmodule

/* rtl/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
  import wisc_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  ex_ctrl_if.exe ctrl,
  input  word_t  data1,
  input  word_t  pc_plus_two,
  input  logic   zero,
  input  logic   msb,
  input  logic   cout,
  input  logic   ofl,
  output logic   cond_bit,
  output word_t  next_pc
);

  logic  eqz, nez, ltz, lez, gez;
  logic  taken;
  logic  redirect;
  word_t pc_a;
  word_t pc_b;
  word_t target;

  assign eqz = zero;
  assign nez = ~zero;
  assign ltz = msb ^ ofl;
  assign lez = ltz | zero;
  assign gez = ~ltz;

  // ALU holds Rt minus Rs, so Rs < Rt means a strictly positive difference
  always_comb begin
    case (ctrl.cond)
      COND_EQ_EQZ: cond_bit = eqz;
      COND_LT_NEZ: cond_bit = ~lez;
      COND_LE_LTZ: cond_bit = gez;
      default:     cond_bit = cout;
    endcase
  end

  always_comb begin
    case (ctrl.cond)
      COND_EQ_EQZ: taken = eqz;
      COND_LT_NEZ: taken = nez;
      COND_LE_LTZ: taken = ltz;
      default:     taken = gez;
    endcase
  end

  // One adder shared by branches, J and JR
  assign pc_a   = ctrl.jump_reg ? data1 : pc_plus_two;
  assign pc_b   = (ctrl.branch || ctrl.jump_reg) ? ctrl.imm8 : ctrl.imm11;
  assign target = pc_a + pc_b;

  assign redirect = (ctrl.jump || (ctrl.branch && taken)) && !ctrl.halt;
  assign next_pc  = redirect ? target : pc_plus_two;

  assert property (@(posedge clk) disable iff (!rst_n) !(ctrl.jump && ctrl.branch))
    else $error("branch_unit: jump and branch both set");

endmodule

/* rtl/execute.sv */
`timescale 1ns/1ps
`include "wisc_macros.svh"

module execute
  import wisc_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  ex_ctrl_if.exe ctrl,
  input  word_t  pc,
  input  word_t  data1,
  input  word_t  data2,
  output word_t  result,
  output word_t  next_pc
);

  word_t alu_b;
  word_t alu_out;
  word_t slbi_out;
  word_t btr_out;
  word_t pc_plus_two;
  logic  cout;
  logic  ofl;
  logic  zero;
  logic  cond_bit;

  // Branches compare Rs against zero through the ALU
  always_comb begin
    case (ctrl.b_sel)
      B_RT:    alu_b = data2;
      B_IMM5:  alu_b = ctrl.imm5;
      default: alu_b = '0;
    endcase
  end

  assign slbi_out    = (data1 << 8) | ctrl.imm8;
  assign pc_plus_two = pc + word_t'(`WISC_PC_STEP);

  always_comb begin
    for (int i = 0; i < `WISC_WIDTH; i++) begin
      btr_out[i] = data1[`WISC_WIDTH-1-i];
    end
  end

  alu alu_inst (
    .a     (data1),
    .b     (alu_b),
    .op    (ctrl.alu_op),
    .cin   (ctrl.cin),
    .inv_a (ctrl.inv_a),
    .inv_b (ctrl.inv_b),
    .sign  (ctrl.sign),
    .out   (alu_out),
    .cout  (cout),
    .ofl   (ofl),
    .zero  (zero)
  );

  branch_unit branch_unit_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl),
    .data1       (data1),
    .pc_plus_two (pc_plus_two),
    .zero        (zero),
    .msb         (alu_out[`WISC_WIDTH-1]),
    .cout        (cout),
    .ofl         (ofl),
    .cond_bit    (cond_bit),
    .next_pc     (next_pc)
  );

  always_comb begin
    case (ctrl.res_sel)
      RES_ALU:  result = alu_out;
      RES_SLBI: result = slbi_out;
      RES_BTR:  result = btr_out;
      default:  result = {{(`WISC_WIDTH-1){1'b0}}, cond_bit};
    endcase
  end

endmodule

/* rtl/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage
  import wisc_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  word_t instr,
  input  word_t pc,
  input  word_t data1,
  input  word_t data2,
  output logic  out_valid,
  output word_t result,
  output word_t next_pc,
  output logic  halted
);

  word_t ex_result;
  word_t ex_next_pc;

  ex_ctrl_if ctrl_if ();

  ex_decode ex_decode_inst (
    .instr (instr),
    .ctrl  (ctrl_if.dec)
  );

  execute execute_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl    (ctrl_if.exe),
    .pc      (pc),
    .data1   (data1),
    .data2   (data2),
    .result  (ex_result),
    .next_pc (ex_next_pc)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      halted    <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        halted <= ctrl_if.halt;
      end
    end
  end

  // Payload holds until the next valid input
  always_ff @(posedge clk) begin
    if (in_valid) begin
      result  <= ex_result;
      next_pc <= ex_next_pc;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid))
    else $error("ex_stage: out_valid unknown");

endmodule

/* testbench/tb_ex_stage.sv */
`timescale 1ns/1ps

module tb_ex_stage
  import wisc_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  in_valid;
  word_t instr;
  word_t pc;
  word_t data1;
  word_t data2;
  logic  out_valid;
  word_t result;
  word_t next_pc;
  logic  halted;

  // One entry per data file line
  logic [8*24-1:0] names[$];
  word_t           vec_instr[$];
  word_t           vec_pc[$];
  word_t           vec_data1[$];
  word_t           vec_data2[$];
  word_t           exp_result[$];
  word_t           exp_next_pc[$];
  logic            exp_halted[$];

  int mismatch_count = 0;
  int timeout_count  = 0;
  int other_count    = 0;

  ex_stage ex_stage_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .instr     (instr),
    .pc        (pc),
    .data1     (data1),
    .data2     (data2),
    .out_valid (out_valid),
    .result    (result),
    .next_pc   (next_pc),
    .halted    (halted)
  );

  always #50 clk = ~clk;

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      mismatch_count++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatch_count++;
      $display("mismatch %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic load_vectors();
    int               fd;
    int               n;
    logic [8*24-1:0]  tok;
    logic [8*160-1:0] line;
    word_t            v[7];
    fd = $fopen("testbench/ex_testdata.txt", "r");
    if (fd == 0) begin
      other_count++;
      $display("error: cannot open testbench/ex_testdata.txt");
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) begin
        break;
      end
      // Comment lines start with a lone hash
      if (tok == "#") begin
        n = $fgets(line, fd);
        continue;
      end
      n = $fscanf(fd, "%h %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
      if (n != 7) begin
        other_count++;
        $display("error: malformed test data line for %0s", tok);
        break;
      end
      names.push_back(tok);
      vec_instr.push_back(v[0]);
      vec_pc.push_back(v[1]);
      vec_data1.push_back(v[2]);
      vec_data2.push_back(v[3]);
      exp_result.push_back(v[4]);
      exp_next_pc.push_back(v[5]);
      exp_halted.push_back(v[6][0]);
    end
    $fclose(fd);
    if (names.size() == 0) begin
      other_count++;
      $display("error: no test vectors were loaded");
    end
  endtask

  // Called right after a rising edge
  task automatic drive_vector(input int i);
    instr    <= vec_instr[i];
    pc       <= vec_pc[i];
    data1    <= vec_data1[i];
    data2    <= vec_data2[i];
    in_valid <= 1'b1;
  endtask

  task automatic wait_output(input string name, output logic seen, output int waited);
    seen   = 1'b0;
    waited = 0;
    while (!seen && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
      seen = (out_valid === 1'b1);
    end
    if (!seen) begin
      timeout_count++;
      $display("timeout: no output valid for %s", name);
    end
  endtask

  task automatic check_outputs(input int i, input string name);
    check_word({name, " result"}, exp_result[i], result);
    check_word({name, " next_pc"}, exp_next_pc[i], next_pc);
    check_flag({name, " halted"}, exp_halted[i], halted);
  endtask

  task automatic run_vector(input int i);
    string name;
    logic  seen;
    int    waited;
    name = $sformatf("%0s", names[i]);
    @(posedge clk);
    drive_vector(i);
    @(posedge clk);
    in_valid <= 1'b0;
    wait_output(name, seen, waited);
    if (seen) begin
      if (waited != 1) begin
        other_count++;
        $display("error: %s output valid came %0d cycles after the input", name, waited);
      end
      check_outputs(i, name);
      @(negedge clk);
      check_flag({name, " valid pulse end"}, 1'b0, out_valid);
    end
  endtask

  // Two inputs on consecutive edges
  task automatic run_back_to_back(input int i, input int j);
    string name_i;
    string name_j;
    logic  seen;
    int    waited;
    name_i = $sformatf("%0s b2b", names[i]);
    name_j = $sformatf("%0s b2b", names[j]);
    @(posedge clk);
    drive_vector(i);
    @(posedge clk);
    drive_vector(j);
    wait_output(name_i, seen, waited);
    if (seen) begin
      if (waited != 1) begin
        other_count++;
        $display("error: %s output valid came %0d cycles after the input", name_i, waited);
      end
      check_outputs(i, name_i);
    end
    @(posedge clk);
    in_valid <= 1'b0;
    @(negedge clk);
    check_flag({name_j, " valid"}, 1'b1, out_valid);
    check_outputs(j, name_j);
    @(negedge clk);
    check_flag({name_j, " valid pulse end"}, 1'b0, out_valid);
  endtask

  initial begin
    rst_n    = 1'b0;
    in_valid = 1'b0;
    instr    = '0;
    pc       = '0;
    data1    = '0;
    data2    = '0;
    load_vectors();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("reset out_valid", 1'b0, out_valid);
    check_flag("reset halted", 1'b0, halted);
    for (int i = 0; i < names.size(); i++) begin
      run_vector(i);
    end
    if (names.size() >= 2) begin
      run_back_to_back(0, 1);
    end
    $display("errors: %0d mismatches, %0d timeouts, %0d other",
             mismatch_count, timeout_count, other_count);
    if (mismatch_count == 0 && timeout_count == 0 && other_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* testbench/ex_testdata.txt */
# name instr pc data1 data2 result next_pc halted, all hex
# data1 is Rs and data2 is Rt, expected values seen after the stage register
add d94c 0100 1234 4321 5555 0102 0
add_wrap d94c 0100 ffff 0002 0001 0102 0
addi_neg 415f 0100 0010 0000 000f 0102 0
sub d94d 0100 0005 0010 000b 0102 0
xor d94e 0100 f0f0 ff00 0ff0 0102 0
andn d94f 0100 f0f0 ff00 00f0 0102 0
xori 515f 0100 00f0 0000 00ef 0102 0
rol d14c 0100 8001 0004 0018 0102 0
sll_low_nibble d14d 0100 1234 0014 2340 0102 0
ror d14e 0100 1234 0008 3412 0102 0
srl d14f 0100 8000 000f 0001 0102 0
roli a143 0100 c000 0000 0006 0102 0
srli b944 0100 abcd 0000 0abc 0102 0
seq_true e14c 0100 1234 1234 0001 0102 0
seq_false e14c 0100 1234 1235 0000 0102 0
slt_true e94c 0100 fffe 0003 0001 0102 0
slt_equal e94c 0100 0005 0005 0000 0102 0
slt_ovf_true e94c 0100 8000 7fff 0001 0102 0
slt_ovf_false e94c 0100 7fff 8000 0000 0102 0
sle_equal f14c 0100 0007 0007 0001 0102 0
sle_false f14c 0100 0008 0007 0000 0102 0
sco_true f94c 0100 ffff 0001 0001 0102 0
sco_false f94c 0100 7fff 0001 0000 0102 0
slbi 91a5 0100 1234 0000 34a5 0102 0
btr c90c 0100 1234 0000 2c48 0102 0
beqz_zero 6110 0100 0000 5a5a 0000 0112 0
beqz_pos 6110 0100 0005 5a5a 0005 0102 0
beqz_neg 6110 0100 fffb 5a5a fffb 0102 0
bnez_zero 69f0 0100 0000 5a5a 0000 0102 0
bnez_pos 69f0 0100 0005 5a5a 0005 00f2 0
bnez_neg 69f0 0100 fffb 5a5a fffb 00f2 0
bltz_zero 7110 0100 0000 5a5a 0000 0102 0
bltz_pos 7110 0100 0005 5a5a 0005 0102 0
bltz_neg 7110 0100 fffb 5a5a fffb 0112 0
bgez_zero 79f0 0100 0000 5a5a 0000 00f2 0
bgez_pos 79f0 0100 0005 5a5a 0005 00f2 0
bgez_neg 79f0 0100 fffb 5a5a fffb 0102 0
j_fwd 2100 0100 0000 0000 0000 0202 0
j_back 27fe 0100 0000 0000 0000 0100 0
jr_fwd 2904 0100 0400 0000 0400 0404 0
jr_back 29fc 0100 0400 0000 0400 03fc 0
nop 0800 0100 0001 0002 0003 0102 0
halt 0000 0100 0000 0000 0000 0102 1
after_halt 0800 0100 0000 0000 0000 0102 0

/* sources.f */
+incdir+rtl
rtl/wisc_pkg.sv
rtl/ex_ctrl_if.sv
rtl/ex_decode.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/execute.sv
rtl/ex_stage.sv
testbench/tb_ex_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
